//--- source/scaler_cfg_pkg.sv
`default_nettype none

package scaler_cfg_pkg;

    // width of one saturating count
    localparam int COUNT_W = 12;

    // one pair of trigger bits per beam
    typedef struct packed {
        logic sub;
        logic pri;
    } beam_pulse_t;

    // one pair of counts per beam, primary in the low field
    typedef struct packed {
        logic [COUNT_W-1:0] sub;
        logic [COUNT_W-1:0] pri;
    } beam_count_t;

    // bank writer FSM
    typedef enum logic [1:0] {
        WR_IDLE  = 2'd0,
        WR_SHIFT = 2'd1,
        WR_FLIP  = 2'd2
    } writer_state_e;

    // beam index width, at least one bit
    function automatic int idx_width(input int nbeams);
        return (nbeams > 1) ? $clog2(nbeams) : 1;
    endfunction

endpackage

`default_nettype wire

//--- source/scaler_bus_pkg.sv
`default_nettype none

package scaler_bus_pkg;

    // word address and data widths of the Wishbone port
    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 32;

    // one count occupies a half-word of a scaler word
    localparam int HALF_W = WB_DAT_W / 2;

    // register kinds by word address
    // scaler words run from REG_SCALER upward
    typedef enum logic [1:0] {
        REG_STATUS  = 2'd0,
        REG_CONTROL = 2'd1,
        REG_SCALER  = 2'd2
    } reg_sel_e;

endpackage

`default_nettype wire

//--- source/scaler_front_end.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_front_end
    import scaler_cfg_pkg::*;
#(
    parameter int NBEAMS        = 8,
    parameter int PERIOD_CYCLES = 100000
) (
    input  wire                      wb_clk_i,
    input  wire                      wb_rst_i,
    input  beam_pulse_t [NBEAMS-1:0] trig_i,
    input  wire                      count_enable_i,
    output beam_pulse_t [NBEAMS-1:0] edge_o,
    output logic                     latch_o
);

    localparam int TMR_W = $clog2(PERIOD_CYCLES + 1);

    // trig_q samples the inputs, trig_d is the previous sample
    beam_pulse_t [NBEAMS-1:0] trig_q;
    beam_pulse_t [NBEAMS-1:0] trig_d;
    logic [TMR_W-1:0]         timer;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            trig_q <= '0;
            trig_d <= '0;
        end else begin
            trig_q <= trig_i;
            trig_d <= trig_q;
        end
    end

    // edge pulse is high for the cycle after the sample
    // nothing reaches the counters while disabled
    always_comb begin
        for (int b = 0; b < NBEAMS; b++) begin
            edge_o[b].pri = count_enable_i & trig_q[b].pri & ~trig_d[b].pri;
            edge_o[b].sub = count_enable_i & trig_q[b].sub & ~trig_d[b].sub;
        end
    end

    // period down-counter
    // zero only in the first cycle after enable, then PERIOD_CYCLES down to 1
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            timer   <= '0;
            latch_o <= 1'b0;
        end else if (!count_enable_i) begin
            timer   <= '0;
            latch_o <= 1'b0;
        end else begin
            latch_o <= (timer == TMR_W'(1));
            if (timer == '0)
                timer <= TMR_W'(PERIOD_CYCLES - 1);
            else if (timer == TMR_W'(1))
                timer <= TMR_W'(PERIOD_CYCLES);
            else
                timer <= timer - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/beam_counter.sv
`timescale 1ns/1ps
`default_nettype none

module beam_counter
    import scaler_cfg_pkg::*;
(
    input  wire         wb_clk_i,
    input  wire         wb_rst_i,
    input  beam_pulse_t edge_i,
    input  wire         latch_i,
    input  wire         shift_i,
    input  beam_count_t chain_i,
    output beam_count_t chain_o
);

    // live counts for the running period
    beam_count_t live;
    // counts frozen at the last latch, also the chain stage
    beam_count_t snap;

    // add one unless already at full scale
    function automatic logic [COUNT_W-1:0] sat_inc(input logic [COUNT_W-1:0] cnt,
                                                   input logic inc);
        if (inc && (cnt != '1))
            return cnt + 1'b1;
        return cnt;
    endfunction

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            live <= '0;
            snap <= '0;
        end else if (latch_i) begin
            // new period starts here
            // an edge in this cycle belongs to it
            snap     <= live;
            live.pri <= COUNT_W'(edge_i.pri);
            live.sub <= COUNT_W'(edge_i.sub);
        end else begin
            live.pri <= sat_inc(live.pri, edge_i.pri);
            live.sub <= sat_inc(live.sub, edge_i.sub);
            // snapshot moves one beam toward the head
            if (shift_i)
                snap <= chain_i;
        end
    end

    assign chain_o = snap;

endmodule

`default_nettype wire

//--- source/scaler_bank_writer.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_bank_writer
    import scaler_cfg_pkg::*;
#(
    parameter  int NBEAMS = 8,
    localparam int IDX_W  = idx_width(NBEAMS)
) (
    input  wire              wb_clk_i,
    input  wire              wb_rst_i,
    input  wire              latch_i,
    input  beam_count_t      chain_i,
    output logic             shift_o,
    output logic             wr_en_o,
    output logic [IDX_W:0]   wr_addr_o,
    output beam_count_t      wr_data_o,
    output logic             read_bank_o,
    output logic             done_o
);

    writer_state_e    state;
    // beam held at the chain head this cycle
    logic [IDX_W-1:0] beam_idx;
    // bank the host reads, the writer fills the other one
    logic             read_bank_q;

    // drain sequence
    // latch at t puts the FSM in WR_SHIFT for t+1 .. t+NBEAMS
    // the head is written every shift cycle, highest beam first
    // WR_FLIP at t+NBEAMS+1 with the new bank already visible
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state       <= WR_IDLE;
            beam_idx    <= '0;
            read_bank_q <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (latch_i) begin
                        state    <= WR_SHIFT;
                        beam_idx <= IDX_W'(NBEAMS - 1);
                    end
                end
                WR_SHIFT: begin
                    if (beam_idx == '0) begin
                        // last beam lands on this edge
                        state       <= WR_FLIP;
                        read_bank_q <= ~read_bank_q;
                    end else begin
                        beam_idx <= beam_idx - 1'b1;
                    end
                end
                WR_FLIP: begin
                    state <= WR_IDLE;
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    // chain advances in the same cycles as the writes
    assign shift_o = (state == WR_SHIFT);

    // write port into the slave storage
    // bank select in the top bit, beam index below
    assign wr_en_o   = (state == WR_SHIFT);
    assign wr_addr_o = {~read_bank_q, beam_idx};
    assign wr_data_o = chain_i;

    assign read_bank_o = read_bank_q;

    // one cycle, together with the bank flip
    assign done_o = (state == WR_FLIP);

endmodule

`default_nettype wire

//--- source/scaler_wb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_wb_slave
    import scaler_cfg_pkg::*;
    import scaler_bus_pkg::*;
#(
    parameter  int NBEAMS = 8,
    localparam int IDX_W  = idx_width(NBEAMS)
) (
    input  wire                 wb_clk_i,
    input  wire                 wb_rst_i,
    input  wire                 wb_cyc_i,
    input  wire                 wb_stb_i,
    input  wire                 wb_we_i,
    input  wire  [WB_ADR_W-1:0] wb_adr_i,
    input  wire  [WB_DAT_W-1:0] wb_dat_i,
    output logic [WB_DAT_W-1:0] wb_dat_o,
    output logic                wb_ack_o,
    input  wire                 wr_en_i,
    input  wire  [IDX_W:0]      wr_addr_i,
    input  beam_count_t         wr_data_i,
    input  wire                 read_bank_i,
    output logic                count_enable_o
);

    localparam int PAD_W = HALF_W - COUNT_W;

    // two banks of one word per beam
    beam_count_t        bank_mem [0:1][0:NBEAMS-1];
    logic [HALF_W-1:0]  period_cnt;
    logic               bus_req;
    reg_sel_e           sel;
    logic [WB_ADR_W-1:0] scal_idx;
    logic [WB_DAT_W-1:0] rd_data;

    // new request, one ack per request
    assign bus_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    // word 0 status, word 1 control, the rest scaler words
    always_comb begin
        if (wb_adr_i == WB_ADR_W'(REG_STATUS))
            sel = REG_STATUS;
        else if (wb_adr_i == WB_ADR_W'(REG_CONTROL))
            sel = REG_CONTROL;
        else
            sel = REG_SCALER;
    end

    assign scal_idx = wb_adr_i - WB_ADR_W'(REG_SCALER);

    always_comb begin
        case (sel)
            REG_STATUS:  rd_data = {period_cnt, {(HALF_W-1){1'b0}}, read_bank_i};
            REG_CONTROL: rd_data = {{(WB_DAT_W-1){1'b0}}, count_enable_o};
            default: begin
                // beyond the last beam reads as zero
                if (scal_idx < WB_ADR_W'(NBEAMS))
                    rd_data = {{PAD_W{1'b0}}, bank_mem[read_bank_i][scal_idx[IDX_W-1:0]].sub,
                               {PAD_W{1'b0}}, bank_mem[read_bank_i][scal_idx[IDX_W-1:0]].pri};
                else
                    rd_data = '0;
            end
        endcase
    end

    // bus side, ack and data one cycle after the request
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wb_ack_o       <= 1'b0;
            count_enable_o <= 1'b0;
        end else begin
            wb_ack_o <= bus_req;
            if (bus_req && wb_we_i && (sel == REG_CONTROL))
                count_enable_o <= wb_dat_i[0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (bus_req)
            wb_dat_o <= rd_data;
    end

    // bank storage and completed period count
    // beam 0 is the last write of a drain
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            period_cnt <= '0;
            for (int k = 0; k < 2; k++)
                for (int b = 0; b < NBEAMS; b++)
                    bank_mem[k][b] <= '0;
        end else if (wr_en_i) begin
            bank_mem[wr_addr_i[IDX_W]][wr_addr_i[IDX_W-1:0]] <= wr_data_i;
            if (wr_addr_i[IDX_W-1:0] == '0)
                period_cnt <= period_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/beam_scaler_top.sv
`timescale 1ns/1ps
`default_nettype none

module beam_scaler_top
    import scaler_cfg_pkg::*;
    import scaler_bus_pkg::*;
#(
    parameter int NBEAMS        = 8,
    parameter int PERIOD_CYCLES = 100000
) (
    input  wire                      wb_clk_i,
    input  wire                      wb_rst_i,
    input  beam_pulse_t [NBEAMS-1:0] trig_i,
    input  wire                      wb_cyc_i,
    input  wire                      wb_stb_i,
    input  wire                      wb_we_i,
    input  wire  [WB_ADR_W-1:0]      wb_adr_i,
    input  wire  [WB_DAT_W-1:0]      wb_dat_i,
    output logic [WB_DAT_W-1:0]      wb_dat_o,
    output logic                     wb_ack_o,
    output logic                     done_o
);

    localparam int IDX_W = idx_width(NBEAMS);

    beam_pulse_t [NBEAMS-1:0] edges;
    logic                     latch;
    logic                     shift;
    logic                     count_enable;
    // chain[b] feeds beam b, chain[NBEAMS] is the head output
    beam_count_t              chain [0:NBEAMS];
    logic                     wr_en;
    logic [IDX_W:0]           wr_addr;
    beam_count_t              wr_data;
    logic                     read_bank;

    scaler_front_end #(
        .NBEAMS        (NBEAMS),
        .PERIOD_CYCLES (PERIOD_CYCLES)
    ) i_front_end (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .trig_i         (trig_i),
        .count_enable_i (count_enable),
        .edge_o         (edges),
        .latch_o        (latch)
    );

    // tail of the chain shifts in zeros
    assign chain[0] = '0;

    for (genvar b = 0; b < NBEAMS; b++) begin : g_beam
        beam_counter i_beam_counter (
            .wb_clk_i (wb_clk_i),
            .wb_rst_i (wb_rst_i),
            .edge_i   (edges[b]),
            .latch_i  (latch),
            .shift_i  (shift),
            .chain_i  (chain[b]),
            .chain_o  (chain[b+1])
        );
    end

    scaler_bank_writer #(
        .NBEAMS (NBEAMS)
    ) i_bank_writer (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .latch_i     (latch),
        .chain_i     (chain[NBEAMS]),
        .shift_o     (shift),
        .wr_en_o     (wr_en),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data),
        .read_bank_o (read_bank),
        .done_o      (done_o)
    );

    scaler_wb_slave #(
        .NBEAMS (NBEAMS)
    ) i_wb_slave (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .wr_en_i        (wr_en),
        .wr_addr_i      (wr_addr),
        .wr_data_i      (wr_data),
        .read_bank_i    (read_bank),
        .count_enable_o (count_enable)
    );

endmodule

`default_nettype wire

//--- tb/beam_scaler_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module beam_scaler_asserts #(
    parameter int NBEAMS = 8
) (
    input wire clk_i,
    input wire rst_i,
    input wire cyc_i,
    input wire stb_i,
    input wire ack_i,
    input wire latch_i,
    input wire shift_i,
    input wire done_i
);

    // failures seen so far, read by the testbench at the end
    int fail_cnt = 0;

    // ack only in the cycle after a new request
    ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |-> $past(cyc_i && stb_i && !ack_i))
        else begin
            $error("wb ack without a request in the previous cycle");
            fail_cnt++;
        end

    // a new request is answered in the next cycle
    req_gets_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        (cyc_i && stb_i && !ack_i) |=> ack_i)
        else begin
            $error("wb request not acknowledged in the next cycle");
            fail_cnt++;
        end

    // ack lasts one cycle
    ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |=> !ack_i)
        else begin
            $error("wb ack held for more than one cycle");
            fail_cnt++;
        end

    // drain takes NBEAMS shifts plus the flip cycle
    done_after_latch: assert property (@(posedge clk_i) disable iff (rst_i)
        latch_i |-> ##(NBEAMS + 1) done_i)
        else begin
            $error("done did not follow latch after NBEAMS+1 cycles");
            fail_cnt++;
        end

    done_only_after_latch: assert property (@(posedge clk_i) disable iff (rst_i)
        done_i |-> $past(latch_i, NBEAMS + 1))
        else begin
            $error("done without a latch NBEAMS+1 cycles earlier");
            fail_cnt++;
        end

    // one shift per beam, then the chain rests
    shift_length: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(shift_i) |-> shift_i [*NBEAMS] ##1 !shift_i)
        else begin
            $error("shift not high for exactly NBEAMS cycles");
            fail_cnt++;
        end

endmodule

// slave side checks the bus, shift seen through the write enable
bind scaler_wb_slave beam_scaler_asserts #(
    .NBEAMS (NBEAMS)
) i_slave_asserts (
    .clk_i   (wb_clk_i),
    .rst_i   (wb_rst_i),
    .cyc_i   (wb_cyc_i),
    .stb_i   (wb_stb_i),
    .ack_i   (wb_ack_o),
    .latch_i (1'b0),
    .shift_i (wr_en_i),
    .done_i  (1'b0)
);

// writer side checks the drain timing
bind scaler_bank_writer beam_scaler_asserts #(
    .NBEAMS (NBEAMS)
) i_writer_asserts (
    .clk_i   (wb_clk_i),
    .rst_i   (wb_rst_i),
    .cyc_i   (1'b0),
    .stb_i   (1'b0),
    .ack_i   (1'b0),
    .latch_i (latch_i),
    .shift_i (shift_o),
    .done_i  (done_o)
);

`default_nettype wire

//--- tb/tb_beam_scaler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_beam_scaler
    import scaler_cfg_pkg::*;
    import scaler_bus_pkg::*;
();

    localparam int NBEAMS         = 6;
    localparam int PERIOD_CYCLES  = 300;
    // two steps per pulse, the train plus the bus reads fit in one period
    localparam int MAX_PULSES     = 120;
    localparam int HOLD_STEPS     = 210;
    localparam int ACK_LIMIT      = 16;
    localparam int TIMEOUT_CYCLES = 8 * PERIOD_CYCLES + 2000;

    logic                     wb_clk;
    logic                     wb_rst;
    beam_pulse_t [NBEAMS-1:0] trig;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [WB_ADR_W-1:0]      wb_adr;
    logic [WB_DAT_W-1:0]      wb_dat_w;
    logic [WB_DAT_W-1:0]      wb_dat_r;
    logic                     wb_ack;
    logic                     done;

    int   seed;
    int   cycle_cnt;
    int   done_cnt;
    int   test_errs;
    int   tests_run;
    int   tests_failed;
    int   check_cnt;
    logic exp_bank;
    int   exp_periods;
    // counts in the readable bank, and the counts of the running period
    logic [COUNT_W-1:0] exp_pri [NBEAMS];
    logic [COUNT_W-1:0] exp_sub [NBEAMS];
    logic [COUNT_W-1:0] new_pri [NBEAMS];
    logic [COUNT_W-1:0] new_sub [NBEAMS];

    beam_scaler_top #(
        .NBEAMS        (NBEAMS),
        .PERIOD_CYCLES (PERIOD_CYCLES)
    ) i_beam_scaler_top (
        .wb_clk_i (wb_clk),
        .wb_rst_i (wb_rst),
        .trig_i   (trig),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .done_o   (done)
    );

    initial wb_clk = 1'b0;
    always #50 wb_clk = ~wb_clk;

    // done pulses, counted on the edge that ends the done cycle
    always @(posedge wb_clk) begin
        if (wb_rst)
            done_cnt <= 0;
        else if (done)
            done_cnt <= done_cnt + 1;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge wb_clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // primary in the low half-word, subthreshold in the high one
    function automatic logic [WB_DAT_W-1:0] scaler_word(input logic [COUNT_W-1:0] pri,
                                                        input logic [COUNT_W-1:0] sub);
        return {HALF_W'(sub), HALF_W'(pri)};
    endfunction

    // periods in the high half, readable bank in bit 0
    function automatic logic [WB_DAT_W-1:0] status_word(input logic bank, input int periods);
        return (WB_DAT_W'(periods) << HALF_W) | WB_DAT_W'(bank);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        check_cnt++;
        assert (act == exp) else begin
            $display("** Error: %s: expected %h, actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // one classic cycle, entered and left on a falling edge
    task automatic bus_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_DAT_W-1:0] wdata,
                             output logic [WB_DAT_W-1:0] rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge wb_clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            $display("error: the slave gave no ack for word %0d", adr);
            test_errs++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic note_flip();
        exp_bank = ~exp_bank;
        exp_periods++;
    endtask

    // returns in the done cycle
    task automatic wait_done();
        do
            @(negedge wb_clk);
        while (done !== 1'b1);
        note_flip();
    endtask

    task automatic pick_counts();
        for (int b = 0; b < NBEAMS; b++) begin
            new_pri[b] = COUNT_W'($unsigned($random(seed)) % MAX_PULSES);
            new_sub[b] = COUNT_W'($unsigned($random(seed)) % MAX_PULSES);
        end
    endtask

    task automatic take_new();
        for (int b = 0; b < NBEAMS; b++) begin
            exp_pri[b] = new_pri[b];
            exp_sub[b] = new_sub[b];
        end
    endtask

    // one-cycle pulses with a one-cycle gap
    task automatic drive_pulse_train();
        for (int i = 0; i < 2 * MAX_PULSES; i++) begin
            for (int b = 0; b < NBEAMS; b++) begin
                trig[b].pri = (i % 2 == 0) && (i / 2 < new_pri[b]);
                trig[b].sub = (i % 2 == 0) && (i / 2 < new_sub[b]);
            end
            @(negedge wb_clk);
        end
        trig = '0;
    endtask

    // long levels, one on the primary and two on the subthreshold input
    task automatic drive_held_levels();
        for (int b = 0; b < NBEAMS; b++) begin
            new_pri[b] = COUNT_W'(1);
            new_sub[b] = COUNT_W'(2);
        end
        for (int i = 0; i < HOLD_STEPS; i++) begin
            for (int b = 0; b < NBEAMS; b++) begin
                trig[b].pri = (i >= 1 + 3 * b) && (i < 61 + 23 * b);
                trig[b].sub = (i >= 4 && i < 50) || (i >= 80 + 10 * b && i < 150 + 10 * b);
            end
            @(negedge wb_clk);
        end
        trig = '0;
    endtask

    task automatic check_bank(input string name);
        logic [WB_DAT_W-1:0] data;
        for (int k = 0; k < NBEAMS; k++) begin
            bus_cycle(1'b0, WB_ADR_W'(REG_SCALER) + WB_ADR_W'(k), '0, data);
            check_val($sformatf("%s word %0d", name, k + 2),
                      scaler_word(exp_pri[k], exp_sub[k]), data);
        end
        // one past the last beam
        bus_cycle(1'b0, WB_ADR_W'(REG_SCALER) + WB_ADR_W'(NBEAMS), '0, data);
        check_val($sformatf("%s unused word", name), '0, data);
        bus_cycle(1'b0, WB_ADR_W'(REG_STATUS), '0, data);
        check_val($sformatf("%s status", name), status_word(exp_bank, exp_periods), data);
    endtask

    // old bank until done is seen at the request, new bank from then on
    task automatic read_across_flip(input string name, input int start_cnt);
        logic [WB_DAT_W-1:0] data;
        logic [WB_DAT_W-1:0] want;
        logic                seen;
        int                  k;
        k    = 0;
        seen = 1'b0;
        while (!seen) begin
            // previous ack must drop first, so the request is taken on the next edge
            if (wb_ack === 1'b1)
                @(negedge wb_clk);
            seen = (done === 1'b1) || (done_cnt != start_cnt);
            if (k == NBEAMS) begin
                bus_cycle(1'b0, WB_ADR_W'(REG_STATUS), '0, data);
                want = seen ? status_word(~exp_bank, exp_periods + 1)
                            : status_word(exp_bank, exp_periods);
            end else begin
                bus_cycle(1'b0, WB_ADR_W'(REG_SCALER) + WB_ADR_W'(k), '0, data);
                want = seen ? scaler_word(new_pri[k], new_sub[k])
                            : scaler_word(exp_pri[k], exp_sub[k]);
            end
            check_val($sformatf("%s read %0d", name, k), want, data);
            k = (k == NBEAMS) ? 0 : k + 1;
        end
    endtask

    initial begin
        logic [WB_DAT_W-1:0] data;
        int                  start_cnt;
        int                  assert_fails;
        seed         = 7;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        check_cnt    = 0;
        exp_bank     = 1'b0;
        exp_periods  = 0;
        trig         = '0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        wb_rst       = 1'b1;
        for (int b = 0; b < NBEAMS; b++) begin
            exp_pri[b] = '0;
            exp_sub[b] = '0;
        end
        repeat (8) @(negedge wb_clk);
        wb_rst = 1'b0;
        @(negedge wb_clk);

        // idle after reset, no drain while disabled
        check_bank("reset");
        start_cnt = done_cnt;
        repeat (2 * PERIOD_CYCLES) @(negedge wb_clk);
        check_val("reset done pulses", 0, done_cnt - start_cnt);
        finish_test("reset");

        // first period after enable is empty
        bus_cycle(1'b1, WB_ADR_W'(REG_CONTROL), 32'd1, data);
        wait_done();
        pick_counts();
        drive_pulse_train();
        wait_done();
        take_new();
        check_bank("random pulses");
        finish_test("random pulses");

        drive_held_levels();
        wait_done();
        take_new();
        check_bank("held levels");
        finish_test("held levels");

        // host reads while the next period is counted and drained
        pick_counts();
        start_cnt = done_cnt;
        fork
            drive_pulse_train();
            read_across_flip("double buffer", start_cnt);
        join
        note_flip();
        take_new();
        check_bank("double buffer");
        finish_test("double buffer");

        // pulses while disabled never reach the counters
        bus_cycle(1'b1, WB_ADR_W'(REG_CONTROL), 32'd0, data);
        bus_cycle(1'b0, WB_ADR_W'(REG_CONTROL), '0, data);
        check_val("disable control", 0, data);
        start_cnt = done_cnt;
        pick_counts();
        drive_pulse_train();
        check_val("disable done pulses", 0, done_cnt - start_cnt);
        bus_cycle(1'b1, WB_ADR_W'(REG_CONTROL), 32'd1, data);
        wait_done();
        for (int b = 0; b < NBEAMS; b++) begin
            exp_pri[b] = '0;
            exp_sub[b] = '0;
        end
        check_bank("disable");
        finish_test("disable");

        assert_fails = i_beam_scaler_top.i_wb_slave.i_slave_asserts.fail_cnt
                     + i_beam_scaler_top.i_bank_writer.i_writer_asserts.fail_cnt;
        check_val("bound assertion failures", 0, assert_fails);
        finish_test("bound assertions");

        $display("tests %0d, passed %0d, failed %0d, checks %0d",
                 tests_run, tests_run - tests_failed, tests_failed, check_cnt);
        if (tests_failed == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/scaler_cfg_pkg.sv
source/scaler_bus_pkg.sv
source/scaler_front_end.sv
source/beam_counter.sv
source/scaler_bank_writer.sv
source/scaler_wb_slave.sv
source/beam_scaler_top.sv
tb/beam_scaler_asserts.sv
tb/tb_beam_scaler.sv

//--- Bender.yml
package:
  name: beam_scaler

sources:
  # packages first, then the design from the leaves up
  - files:
      - source/scaler_cfg_pkg.sv
      - source/scaler_bus_pkg.sv
      - source/scaler_front_end.sv
      - source/beam_counter.sv
      - source/scaler_bank_writer.sv
      - source/scaler_wb_slave.sv
      - source/beam_scaler_top.sv

  # testbench with its bound assertions
  - target: simulation
    files:
      - tb/beam_scaler_asserts.sv
      - tb/tb_beam_scaler.sv
